/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - hdl/memPkg.sv
  - hdl/ctrlPkg.sv
  - hdl/memReqIf.sv
  - hdl/loadStoreQueue.sv
  - hdl/dataCache.sv
  - hdl/memController.sv
  - hdl/memSubsystem.sv
  - target: test
    files:
      - bench/memSubsystem_sva.sv
      - bench/memSubsystemTb.sv

/* bench/memSubsystemTb.sv */
`default_nettype none

module memSubsystemTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int QUEUE_DEPTH    = 4;
    localparam int WAIT_CYCLES    = 2;
    localparam int MEM_BYTES      = 256;
    localparam int ROWS           = 16;
    localparam int PAUSE_CYCLES   = 6;
    localparam int TIMEOUT_CYCLES = ROWS * (3 + WAIT_CYCLES + 4) * 2;

    logic          clk;
    logic          rst;
    logic          rdy;
    logic          reqValid;
    logic          reqStore;
    memPkg::addrT  reqAddr;
    memPkg::dataT  reqData;
    memPkg::lenT   reqLen;
    memPkg::nickT  reqNick;
    logic          queueFull;
    logic          respDone;
    memPkg::dataT  respData;
    memPkg::nickT  respNick;

    // the operation table holds one row per request
    logic          tStore [ROWS];
    memPkg::addrT  tAddr  [ROWS];
    memPkg::dataT  tData  [ROWS];
    memPkg::lenT   tLen   [ROWS];
    memPkg::nickT  tNick  [ROWS];
    logic          tPause [ROWS];

    memPkg::nickT  expNick [$];
    memPkg::dataT  expData [$];
    logic [7:0]    modelMem [MEM_BYTES];

    int            errors     = 0;
    int            checks     = 0;
    int            responses  = 0;
    int            cycleCount = 0;
    logic          sawFull    = 1'b0;
    logic [31:0]   rngState   = 32'd35657;

    memSubsystem #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .WAIT_CYCLES(WAIT_CYCLES),
        .MEM_BYTES  (MEM_BYTES)
    ) i_memSubsystem (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqValid  (reqValid),
        .reqStore  (reqStore),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqLen    (reqLen),
        .reqNick   (reqNick),
        .queueFull (queueFull),
        .respDone  (respDone),
        .respData  (respData),
        .respNick  (respNick)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] nextWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // length code 0 is one byte, 1 is two, anything else a full word
    function automatic int bytesOf(input memPkg::lenT len);
        case (len)
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    task automatic setRow(input int i, input logic st, input memPkg::addrT a,
                          input memPkg::dataT d, input memPkg::lenT l, input logic p);
        tStore[i] = st;
        tAddr[i]  = a;
        tData[i]  = d;
        tLen[i]   = l;
        tNick[i]  = memPkg::nickT'(i + 1);
        tPause[i] = p;
    endtask

    // ========================================================================
    // stimulus table and reference memory
    // ========================================================================

    task automatic buildTable();
        memPkg::addrT a;
        memPkg::addrT c;
        memPkg::addrT e;
        memPkg::addrT f;
        a = nextWord() & 32'hFC;
        c = nextWord() & 32'hFC;
        e = nextWord() & 32'hFC;
        f = nextWord() & 32'hFC;
        setRow(0,  1'b1, a,            nextWord(), 2'd3, 1'b0);
        setRow(1,  1'b0, a,            '0,         2'd3, 1'b0);
        setRow(2,  1'b0, a,            '0,         2'd0, 1'b0);
        setRow(3,  1'b0, a + 1,        '0,         2'd1, 1'b0);
        // the other half of the memory from a has not been written yet
        setRow(4,  1'b0, a ^ 32'h80,   '0,         2'd3, 1'b0);
        setRow(5,  1'b1, c,            nextWord(), 2'd1, 1'b0);
        setRow(6,  1'b1, c + 2,        nextWord(), 2'd0, 1'b0);
        setRow(7,  1'b0, c,            '0,         2'd3, 1'b0);
        setRow(8,  1'b1, e,            nextWord(), 2'd3, 1'b0);
        setRow(9,  1'b0, e + 3,        '0,         2'd0, 1'b0);
        setRow(10, 1'b0, c,            '0,         2'd1, 1'b0);
        setRow(11, 1'b1, a,            nextWord(), 2'd3, 1'b0);
        setRow(12, 1'b0, a,            '0,         2'd3, 1'b1);
        setRow(13, 1'b1, f,            nextWord(), 2'd2, 1'b0);
        setRow(14, 1'b0, f,            '0,         2'd3, 1'b1);
        setRow(15, 1'b0, e,            '0,         2'd2, 1'b0);
    endtask

    // operations run in order, so the model can be updated at acceptance
    task automatic recordExpected(input int i);
        int          idx;
        memPkg::dataT word;
        word = '0;
        for (int b = 0; b < bytesOf(tLen[i]); b++) begin
            idx = (tAddr[i] + 32'(b)) % MEM_BYTES;
            if (tStore[i]) begin
                modelMem[idx] = tData[i][8*b +: 8];
            end else begin
                word[8*b +: 8] = modelMem[idx];
            end
        end
        expNick.push_back(tNick[i]);
        expData.push_back(word);
    endtask

    // called on a rising edge, returns on the edge that takes the request
    task automatic driveRow(input int i);
        reqValid <= 1'b1;
        reqStore <= tStore[i];
        reqAddr  <= tAddr[i];
        reqData  <= tData[i];
        reqLen   <= tLen[i];
        reqNick  <= tNick[i];
        @(negedge clk);
        while (queueFull) begin
            sawFull = 1'b1;
            @(negedge clk);
        end
        recordExpected(i);
        @(posedge clk);
    endtask

    task automatic waitDrain();
        while (expNick.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic checkResponse();
        memPkg::nickT n;
        memPkg::dataT d;
        responses++;
        if (expNick.size() == 0) begin
            errors++;
            $display("a response arrived while no request was outstanding");
        end else begin
            n = expNick.pop_front();
            d = expData.pop_front();
            checks += 2;
            assert (respNick == n) else begin
                errors++;
                $display("ERROR at %0t: nickname expected %h, got %h", $time, n, respNick);
            end
            assert (respData == d) else begin
                errors++;
                $display("ERROR at %0t: data for nickname %h expected %h, got %h",
                         $time, n, d, respData);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && respDone) begin
            if (!rdy) begin
                errors++;
                $display("a response appeared while the pipeline was paused");
            end
            checkResponse();
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        rst      = 1'b1;
        rdy      = 1'b1;
        reqValid = 1'b0;
        reqStore = 1'b0;
        reqAddr  = '0;
        reqData  = '0;
        reqLen   = '0;
        reqNick  = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            modelMem[i] = '0;
        end
        buildTable();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!respDone && !queueFull) else begin
            errors++;
            $display("ERROR at %0t: respDone or queueFull high after reset", $time);
        end
        @(posedge clk);

        for (int i = 0; i < ROWS; i++) begin
            // a paused row starts on an empty pipeline so rdy drops mid access
            if (tPause[i]) begin
                reqValid <= 1'b0;
                waitDrain();
                @(posedge clk);
            end
            driveRow(i);
            if (tPause[i]) begin
                reqValid <= 1'b0;
                repeat (2) @(posedge clk);
                rdy <= 1'b0;
                repeat (PAUSE_CYCLES) @(posedge clk);
                rdy <= 1'b1;
            end
        end
        reqValid <= 1'b0;
        waitDrain();
        repeat (3) @(posedge clk);

        checks += 2;
        assert (responses == ROWS) else begin
            errors++;
            $display("ERROR at %0t: %0d responses expected, got %0d", $time, ROWS, responses);
        end
        assert (sawFull) else begin
            errors++;
            $display("the queue never reported full during back-to-back requests");
        end
        errors += i_memSubsystem.i_dataCache.i_memSubsystemSva.failures;

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/memSubsystem_sva.sv */
`default_nettype none

module memSubsystemSva (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic occupied,
    input logic busy,
    input logic memEn,
    input logic memDone,
    input logic respDone
);

    timeunit 1ns;
    timeprecision 100ps;

    // high from memEn until memDone while one memory access runs
    logic pending;

    // number of failed assertions
    int failures = 0;

    always @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (rdy) begin
            if (memEn) begin
                pending <= 1'b1;
            end else if (memDone) begin
                pending <= 1'b0;
            end
        end
    end

    // ========================================================================
    // cache and memory strobes
    // ========================================================================

    assert property (@(posedge clk) disable iff (rst) $rose(memEn) |-> !$past(occupied))
        else begin
            $error("memEn rose while a request was already held");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst) (memDone && rdy) |=> respDone)
        else begin
            $error("respDone missing one cycle after memDone");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst) $rose(respDone) |-> $past(memDone))
        else begin
            $error("respDone rose without a preceding memDone");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst) pending |-> busy)
        else begin
            $error("busy low while a memory request is outstanding");
            failures++;
        end

endmodule

bind dataCache memSubsystemSva i_memSubsystemSva (
    .clk      (clk),
    .rst      (rst),
    .rdy      (rdy),
    .occupied (occupied),
    .busy     (busy),
    .memEn    (mem.memEn),
    .memDone  (mem.memDone),
    .respDone (respDone)
);

`default_nettype wire

/* hdl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // ========================================================================
    // state machines of the data-memory path
    // ========================================================================

    // queue issue handshake, issued waits until the cache shows busy
    typedef enum logic {
        queueIdle,
        queueIssued
    } queueStateT;

    // memory access sequence
    typedef enum logic [1:0] {
        memIdle,
        memWait,
        memTransfer
    } memStateT;

endpackage

`default_nettype wire

/* hdl/dataCache.sv */
`default_nettype none

module dataCache (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    input  logic          issue,
    input  logic          issueStore,
    input  memPkg::addrT  issueAddr,
    input  memPkg::dataT  issueData,
    input  memPkg::lenT   issueLen,
    input  memPkg::nickT  issueNick,
    output logic          busy,

    output logic          respDone,
    output memPkg::dataT  respData,
    output memPkg::nickT  respNick,

    memReqIf.cache        mem
);

    // ========================================================================
    // single outstanding request
    // ========================================================================

    logic          occupied;
    memPkg::nickT  nick;

    // held high in reset so that the queue cannot issue before it is cleared
    assign busy = rst || occupied;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem.memEn <= 1'b0;
            respDone  <= 1'b0;
            occupied  <= 1'b0;
        end else if (rdy) begin
            // the returned word leaves with the nickname saved at issue
            if (mem.memDone) begin
                respDone <= 1'b1;
                respData <= mem.rdata;
                respNick <= nick;
                occupied <= 1'b0;
            end else begin
                respDone <= 1'b0;
            end

            if (issue) begin
                mem.memEn <= 1'b1;
                mem.store <= issueStore;
                mem.addr  <= issueAddr;
                mem.wdata <= issueData;
                mem.len   <= issueLen;
                nick      <= issueNick;
                occupied  <= 1'b1;
            end else begin
                mem.memEn <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/loadStoreQueue.sv */
`default_nettype none

module loadStoreQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    input  logic          reqValid,
    input  logic          reqStore,
    input  memPkg::addrT  reqAddr,
    input  memPkg::dataT  reqData,
    input  memPkg::lenT   reqLen,
    input  memPkg::nickT  reqNick,
    output logic          full,

    input  logic          busy,
    output logic          issue,
    output logic          issueStore,
    output memPkg::addrT  issueAddr,
    output memPkg::dataT  issueData,
    output memPkg::lenT   issueLen,
    output memPkg::nickT  issueNick
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic          storeQ [QUEUE_DEPTH];
    memPkg::addrT  addrQ  [QUEUE_DEPTH];
    memPkg::dataT  dataQ  [QUEUE_DEPTH];
    memPkg::lenT   lenQ   [QUEUE_DEPTH];
    memPkg::nickT  nickQ  [QUEUE_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    ctrlPkg::queueStateT state;

    // pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(QUEUE_DEPTH));
    assign push = reqValid && !full && rdy;

    // the head leaves only once the cache has taken it, so a busy that has
    // not risen yet cannot trigger a second issue of the same entry
    assign issue = (state == ctrlPkg::queueIdle) && (count != '0) && !busy && rdy;
    assign pop   = (state == ctrlPkg::queueIssued) && busy && rdy;

    assign issueStore = storeQ[head];
    assign issueAddr  = addrQ[head];
    assign issueData  = dataQ[head];
    assign issueLen   = lenQ[head];
    assign issueNick  = nickQ[head];

    always_ff @(posedge clk) begin
        if (push) begin
            storeQ[tail] <= reqStore;
            addrQ[tail]  <= reqAddr;
            dataQ[tail]  <= reqData;
            lenQ[tail]   <= reqLen;
            nickQ[tail]  <= reqNick;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            state <= ctrlPkg::queueIdle;
        end else if (rdy) begin
            if (push) begin
                tail <= nextPtr(tail);
            end
            if (pop) begin
                head <= nextPtr(head);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);

            case (state)
                ctrlPkg::queueIdle: begin
                    if (issue) begin
                        state <= ctrlPkg::queueIssued;
                    end
                end
                ctrlPkg::queueIssued: begin
                    if (busy) begin
                        state <= ctrlPkg::queueIdle;
                    end
                end
                default: state <= ctrlPkg::queueIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/memController.sv */
`default_nettype none

module memController #(
    parameter int WAIT_CYCLES = 2,
    parameter int MEM_BYTES   = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,

    memReqIf.mem   mem
);

    localparam int ADDR_W = $clog2(MEM_BYTES);
    localparam int WAIT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

    memPkg::byteT  ram [MEM_BYTES];

    ctrlPkg::memStateT state;
    logic [WAIT_W-1:0] waitCnt;
    memPkg::countT     byteIdx;
    logic              lastByte;
    logic [ADDR_W-1:0] ramAddr;
    logic [1:0]        lane;

    // the cache keeps addr, len and wdata steady until memDone
    assign ramAddr  = mem.addr[ADDR_W-1:0] + ADDR_W'(byteIdx);
    assign lane     = byteIdx[1:0];
    assign lastByte = (byteIdx == memPkg::byteCount(mem.len) - 1'b1);

    // ========================================================================
    // access sequence
    // ========================================================================

    // the accepting edge counts as the first wait cycle, and the last byte
    // edge raises memDone, so memEn to memDone is WAIT_CYCLES plus the bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                ram[i] <= '0;
            end
            state       <= ctrlPkg::memIdle;
            mem.memDone <= 1'b0;
        end else if (rdy) begin
            mem.memDone <= 1'b0;

            case (state)
                ctrlPkg::memIdle: begin
                    if (mem.memEn) begin
                        waitCnt   <= WAIT_W'(1);
                        byteIdx   <= '0;
                        mem.rdata <= '0;
                        state     <= (WAIT_CYCLES > 1) ? ctrlPkg::memWait
                                                       : ctrlPkg::memTransfer;
                    end
                end

                ctrlPkg::memWait: begin
                    if (waitCnt == WAIT_W'(WAIT_CYCLES - 1)) begin
                        state <= ctrlPkg::memTransfer;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end

                ctrlPkg::memTransfer: begin
                    // a store leaves rdata at zero
                    if (mem.store) begin
                        ram[ramAddr] <= mem.wdata[8*lane +: 8];
                    end else begin
                        mem.rdata[8*lane +: 8] <= ram[ramAddr];
                    end

                    if (lastByte) begin
                        mem.memDone <= 1'b1;
                        state       <= ctrlPkg::memIdle;
                    end else begin
                        byteIdx <= byteIdx + 1'b1;
                    end
                end

                default: state <= ctrlPkg::memIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/memPkg.sv */
`default_nettype none

package memPkg;

    // ========================================================================
    // vector types of the data-memory path
    // ========================================================================

    // byte address, the memory only decodes its low bits
    typedef logic [31:0] addrT;

    // data word, loads are little-endian and zero-extended
    typedef logic [31:0] dataT;

    // length code of an access, see byteCount
    typedef logic [1:0] lenT;

    // reorder-buffer nickname that rides along with each operation
    typedef logic [3:0] nickT;

    typedef logic [7:0] byteT;

    // number of bytes of one access, 1 to 4
    typedef logic [2:0] countT;

    // code 0 is one byte, code 1 two bytes, codes 2 and 3 a full word
    function automatic countT byteCount(input lenT len);
        case (len)
            2'd0:    return countT'(1);
            2'd1:    return countT'(2);
            default: return countT'(4);
        endcase
    endfunction

endpackage

`default_nettype wire

/* hdl/memReqIf.sv */
`default_nettype none

// request link from the data cache to the memory controller
interface memReqIf;

    logic          memEn;
    logic          store;
    memPkg::addrT  addr;
    memPkg::dataT  wdata;
    memPkg::lenT   len;

    logic          memDone;
    memPkg::dataT  rdata;

    // the cache holds the request fields stable while the access runs
    modport cache (
        output memEn, store, addr, wdata, len,
        input  memDone, rdata
    );

    modport mem (
        input  memEn, store, addr, wdata, len,
        output memDone, rdata
    );

endinterface

`default_nettype wire

/* hdl/memSubsystem.sv */
`default_nettype none

module memSubsystem #(
    parameter int QUEUE_DEPTH = 4,
    parameter int WAIT_CYCLES = 2,
    parameter int MEM_BYTES   = 256
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    input  logic          reqValid,
    input  logic          reqStore,
    input  memPkg::addrT  reqAddr,
    input  memPkg::dataT  reqData,
    input  memPkg::lenT   reqLen,
    input  memPkg::nickT  reqNick,
    output logic          queueFull,

    output logic          respDone,
    output memPkg::dataT  respData,
    output memPkg::nickT  respNick
);

    logic          busy;
    logic          issue;
    logic          issueStore;
    memPkg::addrT  issueAddr;
    memPkg::dataT  issueData;
    memPkg::lenT   issueLen;
    memPkg::nickT  issueNick;

    memReqIf i_memReq ();

    loadStoreQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_loadStoreQueue (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .reqValid   (reqValid),
        .reqStore   (reqStore),
        .reqAddr    (reqAddr),
        .reqData    (reqData),
        .reqLen     (reqLen),
        .reqNick    (reqNick),
        .full       (queueFull),
        .busy       (busy),
        .issue      (issue),
        .issueStore (issueStore),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueLen   (issueLen),
        .issueNick  (issueNick)
    );

    dataCache i_dataCache (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issue      (issue),
        .issueStore (issueStore),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueLen   (issueLen),
        .issueNick  (issueNick),
        .busy       (busy),
        .respDone   (respDone),
        .respData   (respData),
        .respNick   (respNick),
        .mem        (i_memReq.cache)
    );

    memController #(
        .WAIT_CYCLES(WAIT_CYCLES),
        .MEM_BYTES  (MEM_BYTES)
    ) i_memController (
        .clk (clk),
        .rst (rst),
        .rdy (rdy),
        .mem (i_memReq.mem)
    );

endmodule

`default_nettype wire

/* list.f */
hdl/memPkg.sv
hdl/ctrlPkg.sv
hdl/memReqIf.sv
hdl/loadStoreQueue.sv
hdl/dataCache.sv
hdl/memController.sv
hdl/memSubsystem.sv
bench/memSubsystem_sva.sv
bench/memSubsystemTb.sv
